// ==== rtl/do_pkg.sv ====
package do_pkg;

	////////////////////////////////////////////////////////////
	// Sizes
	////////////////////////////////////////////////////////////

	// Six banks of four single ended outputs
	localparam int NUM_BANKS = 6;
	localparam int CH_PER_BANK = 4;
	// Each state word holds the levels of two banks
	localparam int STATE_WORDS = NUM_BANKS / 2;
	localparam int FUNCT_W = 4;
	localparam int MODE_W = 2;
	// Register write bus
	localparam int ADDR_W = 8;
	localparam int DATA_W = 16;
	// PWM period and duty, loaded as two half words each
	localparam int PWM_W = 32;
	// Rail gap lasts 2^exp + 2 xclk cycles
	localparam int RAIL_DELAY_EXP_DEFAULT = 16;

	////////////////////////////////////////////////////////////
	// Address map
	////////////////////////////////////////////////////////////

	// Bank n sits at base + n
	localparam logic [ADDR_W-1:0] ADDR_BANK_FUNCT_BASE = 8'h10;
	localparam logic [ADDR_W-1:0] ADDR_BANK_MODE_BASE = 8'h20;
	localparam logic [ADDR_W-1:0] ADDR_BANK_RAILS_BASE = 8'h30;
	// Word k carries bank 2k in bits 3:0, bank 2k+1 in bits 7:4
	localparam logic [ADDR_W-1:0] ADDR_BANK_STATE_BASE = 8'h40;
	localparam logic [ADDR_W-1:0] ADDR_PWM_PERIOD_LS = 8'h50;
	localparam logic [ADDR_W-1:0] ADDR_PWM_PERIOD_MS = 8'h51;
	localparam logic [ADDR_W-1:0] ADDR_PWM_DUTY_LS = 8'h52;
	localparam logic [ADDR_W-1:0] ADDR_PWM_DUTY_MS = 8'h53;

	// Function codes, anything else drives a low signal
	localparam logic [FUNCT_W-1:0] FUNCT_LEVEL = 4'd0;
	localparam logic [FUNCT_W-1:0] FUNCT_PWM = 4'd10;

	// Drive modes
	localparam logic [MODE_W-1:0] MODE_PUSH_PULL = 2'd0;
	localparam logic [MODE_W-1:0] MODE_OPEN_COLLECTOR = 2'd1;
	localparam logic [MODE_W-1:0] MODE_OPEN_EMITTER = 2'd2;
	localparam logic [MODE_W-1:0] MODE_DISABLED = 2'd3;

	////////////////////////////////////////////////////////////
	// Types
	////////////////////////////////////////////////////////////

	// Rail choice 0 or 1 picks a rail, 2 or 3 means none
	typedef struct packed {
		logic [1:0] neg;
		logic [1:0] pos;
	} rail_sel_t;

	// Switch drive, index is the rail number
	// 1 opens the switch since the board inverts these lines
	typedef struct packed {
		logic [1:0] neg;
		logic [1:0] pos;
	} rail_switch_t;

	typedef struct packed {
		logic [CH_PER_BANK-1:0][FUNCT_W-1:0] funct;
		logic [CH_PER_BANK-1:0][MODE_W-1:0] mode;
		logic [CH_PER_BANK-1:0] level;
	} bank_cfg_t;

	typedef struct packed {
		logic [PWM_W-1:0] period;
		logic [PWM_W-1:0] duty;
	} pwm_cfg_t;

	// Upper and lower output transistor drive
	typedef struct packed {
		logic [CH_PER_BANK-1:0] top;
		logic [CH_PER_BANK-1:0] bottom;
	} bank_drive_t;

	// Reset values
	localparam logic [CH_PER_BANK*FUNCT_W-1:0] FUNCT_RESET = '0;
	localparam logic [CH_PER_BANK*MODE_W-1:0] MODE_RESET = {CH_PER_BANK{MODE_DISABLED}};
	localparam logic [CH_PER_BANK-1:0] STATE_RESET = '0;
	// No positive and no negative rail
	localparam rail_sel_t RAILS_RESET = '1;
	localparam rail_switch_t RAILS_ALL_OPEN = '1;
	localparam logic [PWM_W-1:0] PWM_PERIOD_RESET = '1;
	localparam logic [PWM_W-1:0] PWM_DUTY_RESET = 32'h7FFF_FFFF;

endpackage

// ==== rtl/do_bus_regs.sv ====
`timescale 1ns/10ps

module do_bus_regs
(
	input logic xclk,
	input logic reset,
	input logic write_qualified,
	input logic [do_pkg::ADDR_W-1:0] ab,
	input logic [do_pkg::DATA_W-1:0] db_in,
	input logic [do_pkg::NUM_BANKS-1:0] rail_ack,
	output do_pkg::bank_cfg_t [do_pkg::NUM_BANKS-1:0] bank_cfg,
	output do_pkg::rail_sel_t [do_pkg::NUM_BANKS-1:0] rail_sel,
	output logic [do_pkg::NUM_BANKS-1:0] rail_start,
	output do_pkg::pwm_cfg_t pwm_cfg,
	output logic pwm_restart_n
);
	import do_pkg::*;

	// Qualified address hits, one per register
	logic [NUM_BANKS-1:0] funct_hit;
	logic [NUM_BANKS-1:0] mode_hit;
	logic [NUM_BANKS-1:0] rails_hit;
	logic [STATE_WORDS-1:0] state_hit;
	// Period LS, period MS, duty LS, duty MS
	logic [3:0] pwm_hit;

	////////////////////////////////////////////////////////////
	// Address decode
	////////////////////////////////////////////////////////////

	always_comb
	begin
		for (int b = 0; b < NUM_BANKS; b++)
		begin
			funct_hit[b] = write_qualified && (ab == ADDR_BANK_FUNCT_BASE + ADDR_W'(b));
			mode_hit[b] = write_qualified && (ab == ADDR_BANK_MODE_BASE + ADDR_W'(b));
			rails_hit[b] = write_qualified && (ab == ADDR_BANK_RAILS_BASE + ADDR_W'(b));
		end
		for (int k = 0; k < STATE_WORDS; k++)
		begin
			state_hit[k] = write_qualified && (ab == ADDR_BANK_STATE_BASE + ADDR_W'(k));
		end
		pwm_hit[0] = write_qualified && (ab == ADDR_PWM_PERIOD_LS);
		pwm_hit[1] = write_qualified && (ab == ADDR_PWM_PERIOD_MS);
		pwm_hit[2] = write_qualified && (ab == ADDR_PWM_DUTY_LS);
		pwm_hit[3] = write_qualified && (ab == ADDR_PWM_DUTY_MS);
	end

	////////////////////////////////////////////////////////////
	// Bank configuration
	////////////////////////////////////////////////////////////

	always_ff @(posedge xclk or negedge reset)
	begin
		if (!reset)
		begin
			for (int b = 0; b < NUM_BANKS; b++)
			begin
				bank_cfg[b].funct <= FUNCT_RESET;
				bank_cfg[b].mode <= MODE_RESET;
				bank_cfg[b].level <= STATE_RESET;
			end
		end
		else
		begin
			for (int b = 0; b < NUM_BANKS; b++)
			begin
				// Four codes per word, output 1 in the low nibble
				if (funct_hit[b])
					bank_cfg[b].funct <= db_in[CH_PER_BANK*FUNCT_W-1:0];
				if (mode_hit[b])
					bank_cfg[b].mode <= db_in[CH_PER_BANK*MODE_W-1:0];
			end
			// One state word sets the levels of an even and an odd bank
			for (int k = 0; k < STATE_WORDS; k++)
			begin
				if (state_hit[k])
				begin
					bank_cfg[2*k].level <= db_in[CH_PER_BANK-1:0];
					bank_cfg[2*k+1].level <= db_in[2*CH_PER_BANK-1:CH_PER_BANK];
				end
			end
		end
	end

	// Rail selection and start flags
	// Flag is raised by the write, dropped once the sequencer acks
	always_ff @(posedge xclk or negedge reset)
	begin
		if (!reset)
		begin
			rail_sel <= {NUM_BANKS{RAILS_RESET}};
			rail_start <= '0;
		end
		else
		begin
			for (int b = 0; b < NUM_BANKS; b++)
			begin
				if (rails_hit[b])
				begin
					rail_sel[b] <= rail_sel_t'(db_in[3:0]);
					rail_start[b] <= 1'b1;
				end
				else if (rail_ack[b])
					rail_start[b] <= 1'b0;
			end
		end
	end

	// PWM half words
	// Any of them restarts the counter one cycle later
	always_ff @(posedge xclk or negedge reset)
	begin
		if (!reset)
		begin
			pwm_cfg.period <= PWM_PERIOD_RESET;
			pwm_cfg.duty <= PWM_DUTY_RESET;
			pwm_restart_n <= 1'b1;
		end
		else
		begin
			if (pwm_hit[0])
				pwm_cfg.period[DATA_W-1:0] <= db_in;
			if (pwm_hit[1])
				pwm_cfg.period[PWM_W-1:DATA_W] <= db_in;
			if (pwm_hit[2])
				pwm_cfg.duty[DATA_W-1:0] <= db_in;
			if (pwm_hit[3])
				pwm_cfg.duty[PWM_W-1:DATA_W] <= db_in;
			pwm_restart_n <= ~|pwm_hit;
		end
	end

endmodule

// ==== rtl/rail_sequencer.sv ====
`timescale 1ns/10ps

module rail_sequencer
#(
	parameter int RAIL_DELAY_EXP = do_pkg::RAIL_DELAY_EXP_DEFAULT
)
(
	input logic xclk,
	input logic reset,
	input logic rail_start,
	input do_pkg::rail_sel_t rail_sel,
	output logic rail_ack,
	output do_pkg::rail_switch_t do_rails
);
	import do_pkg::*;

	// Idle, all switches open, dead time
	typedef enum logic [1:0] {ST_IDLE, ST_OPEN, ST_WAIT} seq_state_t;

	seq_state_t state;
	logic [RAIL_DELAY_EXP-1:0] delay_cnt;
	// Switch pattern for the requested rails
	rail_switch_t rails_target;

	// Close only the chosen switch on each side
	// Choice bit 1 set means no rail on that side
	always_comb
	begin
		rails_target = RAILS_ALL_OPEN;
		if (!rail_sel.pos[1])
			rails_target.pos[rail_sel.pos[0]] = 1'b0;
		if (!rail_sel.neg[1])
			rails_target.neg[rail_sel.neg[0]] = 1'b0;
	end

	always_ff @(posedge xclk or negedge reset)
	begin
		if (!reset)
		begin
			state <= ST_IDLE;
			delay_cnt <= '0;
			do_rails <= RAILS_ALL_OPEN;
		end
		else
		begin
			case (state)
				ST_IDLE:
				begin
					// Break first
					if (rail_start)
					begin
						do_rails <= RAILS_ALL_OPEN;
						state <= ST_OPEN;
					end
				end
				ST_OPEN:
				begin
					delay_cnt <= '0;
					state <= ST_WAIT;
				end
				ST_WAIT:
				begin
					// A new request starts the gap over
					if (rail_start)
						state <= ST_OPEN;
					else if (&delay_cnt)
					begin
						// Then make
						do_rails <= rails_target;
						state <= ST_IDLE;
					end
					else
						delay_cnt <= delay_cnt + 1'b1;
				end
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	// One cycle ack while everything is open
	assign rail_ack = (state == ST_OPEN);

endmodule

// ==== rtl/pwm_gen.sv ====
`timescale 1ns/10ps

module pwm_gen
(
	input logic xclk,
	input logic reset,
	input logic pwm_restart_n,
	input do_pkg::pwm_cfg_t pwm_cfg,
	output logic pwm_out
);
	import do_pkg::*;

	// Cycle position inside the period
	logic [PWM_W-1:0] count;
	logic [PWM_W-1:0] count_inc;
	logic [PWM_W-1:0] count_next;

	assign count_inc = count + 1'b1;

	// Wrap at the period, or restart after a PWM register write
	// Period of zero holds the count at zero
	always_comb
	begin
		if (!pwm_restart_n || (count_inc >= pwm_cfg.period))
			count_next = '0;
		else
			count_next = count_inc;
	end

	// High while the count is below the duty
	// Duty at or above the period keeps it high, zero keeps it low
	// Output is registered so the switches see no compare glitches
	always_ff @(posedge xclk or negedge reset)
	begin
		if (!reset)
		begin
			count <= '0;
			pwm_out <= 1'b1;
		end
		else
		begin
			count <= count_next;
			pwm_out <= (count_next < pwm_cfg.duty);
		end
	end

endmodule

// ==== rtl/output_bank.sv ====
`timescale 1ns/10ps

module output_bank
(
	input do_pkg::bank_cfg_t bank_cfg,
	input logic pwm_out,
	output do_pkg::bank_drive_t drive
);
	import do_pkg::*;

	// Selected signal for each output
	logic [CH_PER_BANK-1:0] sel_sig;

	// Function select
	// Encoder and Hall codes are gone, they fall to low with the spares
	always_comb
	begin
		for (int c = 0; c < CH_PER_BANK; c++)
		begin
			case (bank_cfg.funct[c])
				FUNCT_LEVEL:
					sel_sig[c] = bank_cfg.level[c];
				FUNCT_PWM:
					sel_sig[c] = pwm_out;
				default:
					sel_sig[c] = 1'b0;
			endcase
		end
	end

	// Drive mode onto the top and bottom switches
	always_comb
	begin
		for (int c = 0; c < CH_PER_BANK; c++)
		begin
			case (bank_cfg.mode[c])
				MODE_PUSH_PULL:
				begin
					drive.top[c] = sel_sig[c];
					drive.bottom[c] = ~sel_sig[c];
				end
				// Sink only
				MODE_OPEN_COLLECTOR:
				begin
					drive.top[c] = 1'b0;
					drive.bottom[c] = ~sel_sig[c];
				end
				// Source only
				MODE_OPEN_EMITTER:
				begin
					drive.top[c] = sel_sig[c];
					drive.bottom[c] = 1'b0;
				end
				// Disabled, both switches off
				default:
				begin
					drive.top[c] = 1'b0;
					drive.bottom[c] = 1'b0;
				end
			endcase
		end
	end

endmodule

// ==== rtl/do_apps.sv ====
`timescale 1ns/10ps

module do_apps
#(
	parameter int RAIL_DELAY_EXP = do_pkg::RAIL_DELAY_EXP_DEFAULT
)
(
	input logic xclk,
	input logic reset,
	input logic write_qualified,
	input logic [do_pkg::ADDR_W-1:0] ab,
	input logic [do_pkg::DATA_W-1:0] db_in,
	output do_pkg::rail_switch_t [do_pkg::NUM_BANKS-1:0] do_rails,
	output do_pkg::bank_drive_t [do_pkg::NUM_BANKS-1:0] dig_out
);
	import do_pkg::*;

	bank_cfg_t [NUM_BANKS-1:0] bank_cfg;
	rail_sel_t [NUM_BANKS-1:0] rail_sel;
	// Start and ack handshake per bank
	logic [NUM_BANKS-1:0] rail_start;
	logic [NUM_BANKS-1:0] rail_ack;
	pwm_cfg_t pwm_cfg;
	logic pwm_restart_n;
	// Shared by every output set to code 10
	logic pwm_out;

	////////////////////////////////////////////////////////////
	// Registers and PWM
	////////////////////////////////////////////////////////////

	do_bus_regs u_regs
	(
		.xclk(xclk),
		.reset(reset),
		.write_qualified(write_qualified),
		.ab(ab),
		.db_in(db_in),
		.rail_ack(rail_ack),
		.bank_cfg(bank_cfg),
		.rail_sel(rail_sel),
		.rail_start(rail_start),
		.pwm_cfg(pwm_cfg),
		.pwm_restart_n(pwm_restart_n)
	);

	pwm_gen u_pwm
	(
		.xclk(xclk),
		.reset(reset),
		.pwm_restart_n(pwm_restart_n),
		.pwm_cfg(pwm_cfg),
		.pwm_out(pwm_out)
	);

	// One rail sequencer and one output bank per bank
	generate
		for (genvar b = 0; b < NUM_BANKS; b++)
		begin : g_bank
			rail_sequencer #(.RAIL_DELAY_EXP(RAIL_DELAY_EXP)) u_rails
			(
				.xclk(xclk),
				.reset(reset),
				.rail_start(rail_start[b]),
				.rail_sel(rail_sel[b]),
				.rail_ack(rail_ack[b]),
				.do_rails(do_rails[b])
			);

			output_bank u_out
			(
				.bank_cfg(bank_cfg[b]),
				.pwm_out(pwm_out),
				.drive(dig_out[b])
			);
		end
	endgenerate

endmodule

// ==== bench/do_apps_tb.sv ====
`timescale 1ns/10ps

module do_apps_tb;
	import do_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 16;
	localparam int RAIL_EXP = 4;
	// Break edge, gap and make edge, counted from the write edge
	localparam int RAIL_CLOSE_CYCLES = (1 << RAIL_EXP) + 2;
	localparam int PWM_PERIOD = 10;
	localparam int PWM_DUTY = 3;
	// Rough length of each test in cycles, reset first
	localparam int TEST_CYCLES = RESET_CYCLES + 12 * 9 + 5 * (RAIL_CLOSE_CYCLES + 6)
		+ 20 + 8 * PWM_PERIOD + 7 * 6 + 10;
	localparam int WATCHDOG_NS = (TEST_CYCLES + 200) * CLK_PERIOD;
	// Holes in the address map, including one past each bank range
	localparam logic [ADDR_W-1:0] UNMAPPED_ADDR [7] =
		'{8'h00, 8'h16, 8'h26, 8'h36, 8'h43, 8'h54, 8'hFF};

	logic xclk;
	logic reset;
	logic write_qualified;
	logic [ADDR_W-1:0] ab;
	logic [DATA_W-1:0] db_in;
	rail_switch_t [NUM_BANKS-1:0] do_rails;
	bank_drive_t [NUM_BANKS-1:0] dig_out;

	// Reference copy of the register map
	logic [FUNCT_W-1:0] model_funct [NUM_BANKS][CH_PER_BANK];
	logic [MODE_W-1:0] model_mode [NUM_BANKS][CH_PER_BANK];
	logic model_level [NUM_BANKS][CH_PER_BANK];
	rail_switch_t model_rails [NUM_BANKS];

	int error_count;
	int check_count;
	string test_name;
	logic [15:0] lfsr_state;

	do_apps #(.RAIL_DELAY_EXP(RAIL_EXP)) UUT
	(
		.xclk(xclk),
		.reset(reset),
		.write_qualified(write_qualified),
		.ab(ab),
		.db_in(db_in),
		.do_rails(do_rails),
		.dig_out(dig_out)
	);

	initial
	begin
		xclk = 1'b0;
		forever #(CLK_PERIOD / 2) xclk = ~xclk;
	end

	// Watchdog
	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
		$display("tests failed");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Concurrent checks per bank
	////////////////////////////////////////////////////////////

	generate
		for (genvar g = 0; g < NUM_BANKS; g++)
		begin : g_watch
			// A closed pattern only ever gives way to all open
			assert property (@(posedge xclk) disable iff (!reset)
				((do_rails[g] != $past(do_rails[g])) && ($past(do_rails[g]) != RAILS_ALL_OPEN))
				|-> (do_rails[g] == RAILS_ALL_OPEN))
			else
			begin
				error_count++;
				$display("bank %0d rails went between two closed patterns without a break", g);
			end
			// No shoot through on any output
			assert property (@(posedge xclk) disable iff (!reset)
				((dig_out[g].top & dig_out[g].bottom) == '0))
			else
			begin
				error_count++;
				$display("bank %0d drives top and bottom of one output together", g);
			end
		end
	endgenerate

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	// Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1, one step per bit
	function automatic logic [15:0] random_bits(input int n);
		logic [15:0] value;
		value = '0;
		for (int i = 0; i < n; i++)
		begin
			value = {value[14:0], lfsr_state[0]};
			lfsr_state = {1'b0, lfsr_state[15:1]} ^ (lfsr_state[0] ? 16'hB400 : 16'h0000);
		end
		return value;
	endfunction

	// Pos choice in bits 1:0, neg in 3:2, 0 means closed
	function automatic rail_switch_t rails_pattern(input logic [3:0] sel);
		logic [3:0] pattern;
		pattern = 4'hF;
		if (sel[1:0] < 2'd2)
			pattern[sel[0]] = 1'b0;
		if (sel[3:2] < 2'd2)
			pattern[2 + sel[2]] = 1'b0;
		return pattern;
	endfunction

	// Function select, then the mode table
	function automatic bank_drive_t expected_drive(input int b, input logic pwm);
		bank_drive_t drv;
		logic s;
		logic [MODE_W-1:0] m;
		for (int c = 0; c < CH_PER_BANK; c++)
		begin
			m = model_mode[b][c];
			if (model_funct[b][c] == FUNCT_LEVEL)
				s = model_level[b][c];
			else if (model_funct[b][c] == FUNCT_PWM)
				s = pwm;
			else
				s = 1'b0;
			drv.top[c] = s && (m == MODE_PUSH_PULL || m == MODE_OPEN_EMITTER);
			drv.bottom[c] = !s && (m == MODE_PUSH_PULL || m == MODE_OPEN_COLLECTOR);
		end
		return drv;
	endfunction

	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		check_count++;
		assert (actual === expected)
		else
		begin
			error_count++;
			$display("[ERROR] %s %s: expected %h, actual %h", test_name, what, expected, actual);
		end
	endtask

	// One bus write, then the model takes the same word
	task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		@(posedge xclk);
		#1;
		write_qualified = 1'b1;
		ab = addr;
		db_in = data;
		@(posedge xclk);
		#1;
		write_qualified = 1'b0;
		for (int b = 0; b < NUM_BANKS; b++)
		begin
			for (int c = 0; c < CH_PER_BANK; c++)
			begin
				if (addr == ADDR_BANK_FUNCT_BASE + b)
					model_funct[b][c] = data[c*FUNCT_W +: FUNCT_W];
				if (addr == ADDR_BANK_MODE_BASE + b)
					model_mode[b][c] = data[c*MODE_W +: MODE_W];
				// Even bank in the low nibble
				if (addr == ADDR_BANK_STATE_BASE + b / 2)
					model_level[b][c] = data[(b % 2) * CH_PER_BANK + c];
			end
		end
	endtask

	task automatic compare_outputs(input logic pwm);
		for (int b = 0; b < NUM_BANKS; b++)
		begin
			check_value($sformatf("dig_out[%0d]", b), expected_drive(b, pwm), dig_out[b]);
			check_value($sformatf("do_rails[%0d]", b), model_rails[b], do_rails[b]);
		end
	endtask

	// Rails write, then follow the break and the make
	task automatic rails_sequence(input int b, input logic [3:0] sel);
		int cycles;
		bus_write(ADDR_BANK_RAILS_BASE + ADDR_W'(b), {12'h000, sel});
		@(negedge xclk);
		check_value("rails before break", model_rails[b], do_rails[b]);
		cycles = 0;
		do
		begin
			@(negedge xclk);
			cycles++;
			if (cycles == 1)
				check_value("rails break", RAILS_ALL_OPEN, do_rails[b]);
			for (int o = 0; o < NUM_BANKS; o++)
			begin
				if (o != b)
					check_value($sformatf("other rails[%0d]", o), model_rails[o], do_rails[o]);
			end
		end
		while (do_rails[b] == RAILS_ALL_OPEN && cycles < 4 * RAIL_CLOSE_CYCLES);
		check_value("rails close cycle", RAIL_CLOSE_CYCLES, cycles);
		model_rails[b] = rails_pattern(sel);
		check_value("rails pattern", model_rails[b], do_rails[b]);
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		int b;
		int cycles;
		int high_n;
		int low_n;
		logic [15:0] r;
		logic [15:0] word;
		logic [3:0] code;
		reset = 1'b0;
		write_qualified = 1'b0;
		ab = '0;
		db_in = '0;
		error_count = 0;
		check_count = 0;
		lfsr_state = 16'd57162;
		// Model starts at the reset values
		for (int i = 0; i < NUM_BANKS; i++)
		begin
			model_rails[i] = RAILS_ALL_OPEN;
			for (int c = 0; c < CH_PER_BANK; c++)
			begin
				model_funct[i][c] = FUNCT_LEVEL;
				model_mode[i][c] = MODE_DISABLED;
				model_level[i][c] = 1'b0;
			end
		end
		repeat (RESET_CYCLES) @(posedge xclk);
		#1;
		reset = 1'b1;
		@(negedge xclk);
		test_name = "reset";
		compare_outputs(1'b0);

		// Level codes with random modes and levels
		test_name = "level";
		for (int i = 0; i < 12; i++)
		begin
			b = random_bits(3) % NUM_BANKS;
			bus_write(ADDR_BANK_FUNCT_BASE + ADDR_W'(b), 16'h0000);
			r = random_bits(8);
			bus_write(ADDR_BANK_MODE_BASE + ADDR_W'(b), {8'h00, r[7:0]});
			@(negedge xclk);
			compare_outputs(1'b0);
			r = random_bits(8);
			bus_write(ADDR_BANK_STATE_BASE + ADDR_W'(b / 2), {8'h00, r[7:0]});
			@(negedge xclk);
			compare_outputs(1'b0);
		end

		// Break before make, positive side always picks a rail
		test_name = "rails";
		for (int i = 0; i < 4; i++)
		begin
			b = random_bits(3) % NUM_BANKS;
			r = random_bits(3);
			rails_sequence(b, {r[2:1], 1'b0, r[0]});
		end
		// Same bank again, so a closed pattern has to break first
		r = random_bits(3);
		rails_sequence(b, {r[2:1], 1'b0, r[0]});

		// PWM on bank 0 output 0 in push pull
		test_name = "pwm";
		bus_write(ADDR_BANK_FUNCT_BASE, {12'h000, FUNCT_PWM});
		bus_write(ADDR_BANK_MODE_BASE, 16'h0000);
		bus_write(ADDR_PWM_PERIOD_LS, DATA_W'(PWM_PERIOD));
		bus_write(ADDR_PWM_PERIOD_MS, 16'h0000);
		bus_write(ADDR_PWM_DUTY_LS, DATA_W'(PWM_DUTY));
		bus_write(ADDR_PWM_DUTY_MS, 16'h0000);
		@(negedge xclk);
		// Line up on the start of a high phase
		cycles = 0;
		while (dig_out[0].top[0] !== 1'b0 && cycles < 4 * PWM_PERIOD)
		begin
			@(negedge xclk);
			cycles++;
		end
		while (dig_out[0].top[0] !== 1'b1 && cycles < 4 * PWM_PERIOD)
		begin
			@(negedge xclk);
			cycles++;
		end
		if (cycles >= 4 * PWM_PERIOD)
		begin
			error_count++;
			$display("pwm output on bank 0 output 0 never started a high phase");
		end
		for (int p = 0; p < 3; p++)
		begin
			high_n = 0;
			low_n = 0;
			while (dig_out[0].top[0] === 1'b1 && high_n < 4 * PWM_PERIOD)
			begin
				high_n++;
				@(negedge xclk);
			end
			while (dig_out[0].top[0] === 1'b0 && low_n < 4 * PWM_PERIOD)
			begin
				low_n++;
				@(negedge xclk);
			end
			check_value("high cycles", PWM_DUTY, high_n);
			check_value("low cycles", PWM_PERIOD - PWM_DUTY, low_n);
		end
		// Zero duty holds the output low
		test_name = "pwm duty zero";
		bus_write(ADDR_PWM_DUTY_LS, 16'h0000);
		@(negedge xclk);
		repeat (2 * PWM_PERIOD)
		begin
			@(negedge xclk);
			compare_outputs(1'b0);
		end

		// Spare function codes in push pull
		test_name = "unused code";
		b = random_bits(3) % NUM_BANKS;
		r = random_bits(16);
		for (int c = 0; c < CH_PER_BANK; c++)
		begin
			code = r[c*FUNCT_W +: FUNCT_W];
			if (code == FUNCT_LEVEL || code == FUNCT_PWM)
				code = 4'd11;
			word[c*FUNCT_W +: FUNCT_W] = code;
		end
		bus_write(ADDR_BANK_FUNCT_BASE + ADDR_W'(b), word);
		bus_write(ADDR_BANK_MODE_BASE + ADDR_W'(b), 16'h0000);
		@(negedge xclk);
		check_value("push pull drive", 8'h0F, dig_out[b]);
		compare_outputs(1'b0);

		// Holes in the map leave every output alone
		test_name = "unmapped";
		for (int i = 0; i < 7; i++)
		begin
			bus_write(UNMAPPED_ADDR[i], random_bits(16));
			@(negedge xclk);
			@(negedge xclk);
			compare_outputs(1'b0);
		end

		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// ==== do_apps.f ====
rtl/do_pkg.sv
rtl/do_bus_regs.sv
rtl/rail_sequencer.sv
rtl/pwm_gen.sv
rtl/output_bank.sv
rtl/do_apps.sv
bench/do_apps_tb.sv

// ==== Bender.yml ====
package:
  name: do_apps

sources:
  - rtl/do_pkg.sv
  - rtl/do_bus_regs.sv
  - rtl/rail_sequencer.sv
  - rtl/pwm_gen.sv
  - rtl/output_bank.sv
  - rtl/do_apps.sv
  - target: test
    files:
      - bench/do_apps_tb.sv
